/* spi_pkg.sv */
package spi_pkg;

  // One datagram per chip select window
  localparam int SPI_FRAME_BITS = 40;

  typedef logic [SPI_FRAME_BITS-1:0] spi_frame_t;

  // System clocks per sclk half period
  localparam int SPI_HALF_PERIOD = 8;

  // Wide enough to count up to SPI_FRAME_BITS
  localparam int SPI_BIT_CNT_WIDTH = 6;

  // Status byte arrives first, so it sits at the top of the received frame
  localparam int STATUS_MSB = 39;
  localparam int STATUS_LSB = 32;

endpackage

/* motor_cfg_pkg.sv */
package motor_cfg_pkg;

  // Step rate divider width
  localparam int STEP_WIDTH = 64;

  // Driver datagram layout, address byte then data word
  localparam int REG_ADDR_BITS = 8;
  localparam int REG_DATA_BITS = 32;

  typedef logic [REG_ADDR_BITS+REG_DATA_BITS-1:0] datagram_t;

  // Top address bit marks a register write
  localparam logic [REG_ADDR_BITS-1:0] WRITE_FLAG = 8'h80;

  // Driver register map
  localparam logic [REG_ADDR_BITS-1:0] ADDR_GCONF      = 8'h00;
  localparam logic [REG_ADDR_BITS-1:0] ADDR_IHOLD_IRUN = 8'h10;
  localparam logic [REG_ADDR_BITS-1:0] ADDR_TPOWERDOWN = 8'h11;
  localparam logic [REG_ADDR_BITS-1:0] ADDR_TPWMTHRS   = 8'h13;
  localparam logic [REG_ADDR_BITS-1:0] ADDR_CHOPCONF   = 8'h6C;
  localparam logic [REG_ADDR_BITS-1:0] ADDR_PWMCONF    = 8'h70;

  // Power-up write sequence
  localparam int SETUP_COUNT = 6;

  typedef logic [2:0] setup_idx_t;

  localparam datagram_t SETUP_TABLE [SETUP_COUNT] = '{
    // TOFF 3, HSTRT 4, HEND 1, TBL 2, spread cycle chopper
    {ADDR_CHOPCONF | WRITE_FLAG, 32'h0001_00C3},
    // Hold current 10, run current 31, hold delay 6
    {ADDR_IHOLD_IRUN | WRITE_FLAG, 32'h0006_1F0A},
    // Standstill delay before current reduction
    {ADDR_TPOWERDOWN | WRITE_FLAG, 32'h0000_000A},
    // Quiet PWM mode on
    {ADDR_GCONF | WRITE_FLAG, 32'h0000_0004},
    // Switch-over velocity threshold, roughly 30 RPM
    {ADDR_TPWMTHRS | WRITE_FLAG, 32'h0000_01F4},
    // Auto amplitude, PWM freq 2/1024 fclk, amplitude 200, grad 1
    {ADDR_PWMCONF | WRITE_FLAG, 32'h0004_01C8}
  };

endpackage

/* spi_master.sv */
`timescale 1ns/1ns

module spi_master (
  input  logic                clk_in,
  input  logic                reset_n_in,
  input  spi_pkg::spi_frame_t frame,
  input  logic                send,
  input  logic                miso,
  output logic                sclk,
  output logic                mosi,
  output logic                cs_n,
  output spi_pkg::spi_frame_t rx_frame,
  output logic                done,
  output logic                busy
);
  import spi_pkg::*;

  logic [$clog2(SPI_HALF_PERIOD)-1:0] half_cnt;
  logic [SPI_BIT_CNT_WIDTH-1:0]       bit_cnt;
  logic                               half_end;
  logic                               last_bit;
  logic                               fall_evt;
  logic                               rise_evt;
  logic                               end_evt;
  spi_frame_t                         tx_shift;
  spi_frame_t                         rx_shift;

  assign half_end = busy && (half_cnt == $bits(half_cnt)'(SPI_HALF_PERIOD - 1));
  assign last_bit = (bit_cnt == $bits(bit_cnt)'(SPI_FRAME_BITS));

  // Mode 3: drive on falling sclk, sample on rising sclk
  assign fall_evt = half_end && sclk && !last_bit;
  assign rise_evt = half_end && !sclk;
  // One idle half period after the last rising edge closes the frame
  assign end_evt  = half_end && sclk && last_bit;

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      busy     <= 1'b0;
      cs_n     <= 1'b1;
      sclk     <= 1'b1;
      mosi     <= 1'b0;
      done     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (send) begin
          busy     <= 1'b1;
          cs_n     <= 1'b0;
          half_cnt <= '0;
          bit_cnt  <= '0;
        end
      end else if (!half_end) begin
        half_cnt <= half_cnt + 1'b1;
      end else begin
        half_cnt <= '0;
        if (rise_evt) begin
          sclk    <= 1'b1;
          bit_cnt <= bit_cnt + 1'b1;
        end else if (fall_evt) begin
          sclk <= 1'b0;
          mosi <= tx_shift[SPI_FRAME_BITS-1];
        end else if (end_evt) begin
          busy <= 1'b0;
          cs_n <= 1'b1;
          mosi <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Transmit and receive shift registers
  always_ff @(posedge clk_in) begin
    if (!busy && send) begin
      tx_shift <= frame;
    end else if (fall_evt) begin
      tx_shift <= {tx_shift[SPI_FRAME_BITS-2:0], 1'b0};
    end
    if (rise_evt) begin
      rx_shift <= {rx_shift[SPI_FRAME_BITS-2:0], miso};
    end
  end

  // Holds the last reply until the next frame starts shifting
  assign rx_frame = rx_shift;

  // Callers must wait for the previous frame to finish
  a_no_send_while_busy: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    send |-> !busy);

  a_cs_idle_high: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    !busy |-> cs_n);

endmodule

/* step_divider.sv */
`timescale 1ns/1ns

module step_divider (
  input  logic                                clk_in,
  input  logic                                reset_n_in,
  input  logic [motor_cfg_pkg::STEP_WIDTH-1:0] max,
  output logic                                tick_wave
);
  import motor_cfg_pkg::*;

  logic [STEP_WIDTH-1:0] count;
  logic                  at_max;

  // Greater-or-equal lets a lowered max take effect without wrapping
  assign at_max = (count >= max);

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      count     <= '0;
      tick_wave <= 1'b0;
    end else if (max == '0) begin
      // Zero speed parks the output
      count     <= '0;
      tick_wave <= 1'b0;
    end else if (at_max) begin
      count     <= '0;
      tick_wave <= ~tick_wave;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Output period is 2 * (max + 1) clocks
  a_zero_max_low: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    (max == '0) |=> !tick_wave);

endmodule

/* motor_driver.sv */
`timescale 1ns/1ns

module motor_driver (
  input  logic                                               clk_in,
  input  logic                                               reset_n_in,
  input  logic                                               miso,
  input  logic                                               step_enable,
  input  logic [motor_cfg_pkg::STEP_WIDTH-1:0]                speed,
  output logic                                               sclk,
  output logic                                               mosi,
  output logic                                               cs_n,
  output logic                                               step,
  output logic [spi_pkg::STATUS_MSB-spi_pkg::STATUS_LSB:0]     status,
  output logic                                               setup_done
);
  import spi_pkg::*;
  import motor_cfg_pkg::*;

  typedef enum logic [1:0] {
    s_issue,
    s_wait,
    s_finished
  } seq_state_t;

  seq_state_t state;
  setup_idx_t idx;
  spi_frame_t frame;
  spi_frame_t rx_frame;
  logic       send;
  logic       done;
  logic       busy;
  logic       tick_wave;

  // Table entry stays put from send until done
  assign frame      = SETUP_TABLE[idx];
  assign setup_done = (state == s_finished);

  spi_master i_spi_master (
    .clk_in     (clk_in),
    .reset_n_in (reset_n_in),
    .frame      (frame),
    .send       (send),
    .miso       (miso),
    .sclk       (sclk),
    .mosi       (mosi),
    .cs_n       (cs_n),
    .rx_frame   (rx_frame),
    .done       (done),
    .busy       (busy)
  );

  // Power-up sequencer, one write per table entry
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state  <= s_issue;
      idx    <= '0;
      send   <= 1'b0;
      status <= '0;
    end else begin
      send <= 1'b0;
      case (state)
        s_issue: begin
          send  <= 1'b1;
          state <= s_wait;
        end
        s_wait: begin
          if (done) begin
            status <= rx_frame[STATUS_MSB:STATUS_LSB];
            if (idx == setup_idx_t'(SETUP_COUNT - 1)) begin
              state <= s_finished;
            end else begin
              // Next write goes out right behind the reply
              idx  <= idx + 1'b1;
              send <= 1'b1;
            end
          end
        end
        s_finished: begin
          state <= s_finished;
        end
        default: begin
          state <= s_issue;
        end
      endcase
    end
  end

  step_divider i_step_divider (
    .clk_in     (clk_in),
    .reset_n_in (reset_n_in),
    .max        (speed),
    .tick_wave  (tick_wave)
  );

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      step <= 1'b0;
    end else begin
      step <= step_enable && tick_wave;
    end
  end

  a_idx_in_table: assert property (@(posedge clk_in) disable iff (!reset_n_in)
    send |-> (idx <= setup_idx_t'(SETUP_COUNT - 1)) && !busy);

endmodule

/* stepper_axes_top.sv */
`timescale 1ns/1ns

module stepper_axes_top (
  input  logic                                           clk_in,
  input  logic                                           reset_n_in,
  input  logic                                           x_miso,
  input  logic                                           x_step_enable,
  input  logic [motor_cfg_pkg::STEP_WIDTH-1:0]            x_speed,
  output logic                                           x_sclk,
  output logic                                           x_mosi,
  output logic                                           x_cs_n,
  output logic                                           x_step,
  output logic [spi_pkg::STATUS_MSB-spi_pkg::STATUS_LSB:0] x_status,
  output logic                                           x_setup_done,
  input  logic                                           y_miso,
  input  logic                                           y_step_enable,
  input  logic [motor_cfg_pkg::STEP_WIDTH-1:0]            y_speed,
  output logic                                           y_sclk,
  output logic                                           y_mosi,
  output logic                                           y_cs_n,
  output logic                                           y_step,
  output logic [spi_pkg::STATUS_MSB-spi_pkg::STATUS_LSB:0] y_status,
  output logic                                           y_setup_done
);

  // Each axis has its own driver chip on a private SPI link
  motor_driver i_axis_x (
    .clk_in      (clk_in),
    .reset_n_in  (reset_n_in),
    .miso        (x_miso),
    .step_enable (x_step_enable),
    .speed       (x_speed),
    .sclk        (x_sclk),
    .mosi        (x_mosi),
    .cs_n        (x_cs_n),
    .step        (x_step),
    .status      (x_status),
    .setup_done  (x_setup_done)
  );

  motor_driver i_axis_y (
    .clk_in      (clk_in),
    .reset_n_in  (reset_n_in),
    .miso        (y_miso),
    .step_enable (y_step_enable),
    .speed       (y_speed),
    .sclk        (y_sclk),
    .mosi        (y_mosi),
    .cs_n        (y_cs_n),
    .step        (y_step),
    .status      (y_status),
    .setup_done  (y_setup_done)
  );

endmodule

/* tb_stepper_axes.sv */
`timescale 1ns/1ns

// Behavioral SPI driver chip, one per axis
module driver_chip_model (
  input  logic        clk_in,
  input  logic [7:0]  axis_tag,
  input  logic [47:0] replies,
  input  logic        sclk,
  input  logic        mosi,
  input  logic        cs_n,
  input  logic [7:0]  status,
  input  logic        setup_done,
  output logic        miso,
  output int          frames_seen,
  output int          err_cnt
);
  import motor_cfg_pkg::*;
  import spi_pkg::*;

  spi_frame_t rx_shift;
  spi_frame_t tx_shift;
  int         rise_cnt;
  logic [7:0] sent_byte;

  initial begin
    miso = 1'b0;
    frames_seen = 0;
    err_cnt = 0;
    forever begin
      @(negedge cs_n);
      rise_cnt = 0;
      sent_byte = (frames_seen < SETUP_COUNT) ? replies[47 - 8 * frames_seen -: 8] : 8'h00;
      tx_shift = {sent_byte, 32'h0};
      // Reply goes out on falling sclk, command comes in on rising sclk
      while (!cs_n) begin
        @(sclk or cs_n);
        if (!cs_n && sclk) begin
          rx_shift = {rx_shift[SPI_FRAME_BITS-2:0], mosi};
          rise_cnt++;
        end else if (!cs_n) begin
          #10;
          miso = tx_shift[SPI_FRAME_BITS-1];
          tx_shift = tx_shift << 1;
        end
      end
      // Status lands one clock after the frame closes
      @(posedge clk_in);
      #10;
      if (frames_seen >= SETUP_COUNT) begin
        $display("Axis %c sent a frame after its power-up sequence had finished", axis_tag);
        err_cnt++;
      end else begin
        assert (rise_cnt == SPI_FRAME_BITS) else begin
          $display("MISMATCH %c_sclk rising edges got %0h expected %0h",
                   axis_tag, rise_cnt, SPI_FRAME_BITS);
          err_cnt++;
        end
        assert (rx_shift == SETUP_TABLE[frames_seen]) else begin
          $display("MISMATCH %c_mosi frame %0d got %0h expected %0h",
                   axis_tag, frames_seen, rx_shift, SETUP_TABLE[frames_seen]);
          err_cnt++;
        end
        assert (status == sent_byte) else begin
          $display("MISMATCH %c_status got %0h expected %0h", axis_tag, status, sent_byte);
          err_cnt++;
        end
        assert (setup_done == (frames_seen == SETUP_COUNT - 1)) else begin
          $display("MISMATCH %c_setup_done after frame %0d got %0h expected %0h", axis_tag,
                   frames_seen, setup_done, frames_seen == SETUP_COUNT - 1);
          err_cnt++;
        end
      end
      frames_seen++;
    end
  end

endmodule

module tb_stepper_axes;
  import motor_cfg_pkg::*;

  localparam int clk_period = 100;
  // Six setup frames of up to 700 clocks plus the step tests, doubled
  localparam int watchdog_ns = (6 * 700 + 4000) * 2 * clk_period;

  logic                  clk_in;
  logic                  reset_n_in;
  logic                  x_miso, x_step_enable, x_sclk, x_mosi, x_cs_n, x_step, x_setup_done;
  logic                  y_miso, y_step_enable, y_sclk, y_mosi, y_cs_n, y_step, y_setup_done;
  logic [STEP_WIDTH-1:0] x_speed;
  logic [STEP_WIDTH-1:0] y_speed;
  logic [7:0]            x_status;
  logic [7:0]            y_status;
  logic [47:0]           x_replies;
  logic [47:0]           y_replies;
  int                    x_frames, y_frames, x_chip_errs, y_chip_errs;
  int                    err_cnt, pass_cnt, fail_cnt, start_errs, x_rate, y_rate;
  int                    overlap_cycles = 0;

  stepper_axes_top i_dut (.*);

  driver_chip_model i_x_chip (
    .clk_in(clk_in), .axis_tag("x"), .replies(x_replies), .sclk(x_sclk), .mosi(x_mosi),
    .cs_n(x_cs_n), .status(x_status), .setup_done(x_setup_done), .miso(x_miso),
    .frames_seen(x_frames), .err_cnt(x_chip_errs)
  );

  driver_chip_model i_y_chip (
    .clk_in(clk_in), .axis_tag("y"), .replies(y_replies), .sclk(y_sclk), .mosi(y_mosi),
    .cs_n(y_cs_n), .status(y_status), .setup_done(y_setup_done), .miso(y_miso),
    .frames_seen(y_frames), .err_cnt(y_chip_errs)
  );

  initial begin
    clk_in = 1'b0;
    forever #(clk_period / 2) clk_in = ~clk_in;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout: run did not finish within %0d ns", watchdog_ns);
    $display("Simulation FAILED");
    $finish;
  end

  // Both chip selects low at once means the axes really run side by side
  always @(negedge clk_in) begin
    overlap_cycles += int'(!x_cs_n && !y_cs_n);
  end

  function automatic int total_errors();
    return err_cnt + x_chip_errs + y_chip_errs;
  endfunction

  function automatic logic axis_step(input int axis);
    return (axis == 0) ? x_step : y_step;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("MISMATCH %s got %0h expected %0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name);
    if (total_errors() == start_errs) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed", name);
    end
    start_errs = total_errors();
  endtask

  task automatic wait_drive_slot();
    @(posedge clk_in);
    #10;
  endtask

  // Rise to rise spacing of one axis's step output
  task automatic check_step_period(input int axis, input int rate);
    int   cycles;
    int   last_rise;
    int   rises;
    logic prev;
    cycles = 0;
    last_rise = 0;
    rises = 0;
    prev = axis_step(axis);
    while (rises < 4 && cycles < 400) begin
      @(negedge clk_in);
      cycles++;
      if (axis_step(axis) && !prev) begin
        if (rises > 0) begin
          check_value(axis == 0 ? "x_step period" : "y_step period",
                      64'(cycles - last_rise), 64'(2 * (rate + 1)));
        end
        last_rise = cycles;
        rises++;
      end
      prev = axis_step(axis);
    end
    assert (rises == 4) else begin
      $display("Axis %0d step output stopped toggling at speed %0d", axis, rate);
      err_cnt++;
    end
  endtask

  task automatic check_step_low(input int cycles);
    int high_cnt;
    high_cnt = 0;
    repeat (cycles) begin
      @(negedge clk_in);
      high_cnt += int'(x_step || y_step);
    end
    check_value("x_step y_step high cycles", 64'(high_cnt), 64'h0);
  endtask

  initial begin
    void'($urandom(46709));
    x_replies = {16'($urandom), 32'($urandom)};
    y_replies = {16'($urandom), 32'($urandom)};
    x_rate = 1 + int'($urandom % 20);
    y_rate = 1 + int'($urandom % 20);
    if (y_rate == x_rate) y_rate = (x_rate % 20) + 1;
    reset_n_in = 1'b0;
    x_step_enable = 1'b0;
    y_step_enable = 1'b0;
    x_speed = '0;
    y_speed = '0;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    start_errs = 0;

    repeat (5) @(posedge clk_in);
    #10;
    check_value("x_cs_n x_sclk x_step x_setup_done", {x_cs_n, x_sclk, x_step, x_setup_done}, 64'hC);
    check_value("y_cs_n y_sclk y_step y_setup_done", {y_cs_n, y_sclk, y_step, y_setup_done}, 64'hC);
    check_value("x_status", 64'(x_status), 64'h0);
    check_value("y_status", 64'(y_status), 64'h0);
    report_test("reset state");
    reset_n_in = 1'b1;

    wait (x_frames == SETUP_COUNT && y_frames == SETUP_COUNT);
    assert (overlap_cycles > 0) else begin
      $display("Frames of the two axes never overlapped in time");
      err_cnt++;
    end
    report_test("power-up frames, status and overlap");

    wait_drive_slot();
    x_speed = 64'(x_rate);
    y_speed = 64'(y_rate);
    x_step_enable = 1'b1;
    y_step_enable = 1'b1;
    check_step_period(0, x_rate);
    check_step_period(1, y_rate);
    report_test("step period");

    wait_drive_slot();
    x_step_enable = 1'b0;
    y_step_enable = 1'b0;
    wait_drive_slot();
    check_step_low(100);
    report_test("step disabled");

    wait_drive_slot();
    x_step_enable = 1'b1;
    y_step_enable = 1'b1;
    x_speed = '0;
    y_speed = '0;
    // Divider parks first, then the step register follows
    repeat (2) wait_drive_slot();
    check_step_low(100);
    check_value("x_setup_done y_setup_done", {x_setup_done, y_setup_done}, 64'h3);
    report_test("zero speed and setup_done held");

    $display("Tests done: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && total_errors() == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
spi_pkg.sv
motor_cfg_pkg.sv
spi_master.sv
step_divider.sv
motor_driver.sv
stepper_axes_top.sv
tb_stepper_axes.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the two-axis stepper testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_stepper_axes -f compile.f
./obj_dir/Vtb_stepper_axes | tee sim.log
if grep -q "Simulation PASSED" sim.log; then
  echo "run_sim: simulation passed"
else
  echo "run_sim: simulation failed"
  exit 1
fi
